/* logic/core_pkg.sv */
package core_pkg;

    localparam int DATA_W  = 32;
    localparam int REG_AW  = 5;
    localparam int REG_NUM = 32;
    localparam int IMEM_AW = 10;
    localparam int DMEM_AW = 10;

    localparam logic [DATA_W-1:0] RESET_PC = 32'h1c00_0000;

    // 3R format, opcode in bits 31..15
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_SLTU  = 17'h00025;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;

    // 2RI12 format, opcode in bits 31..22
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_LD_W   = 10'h0a2;
    localparam logic [9:0] OP_ST_W   = 10'h0a6;

    // 1RI20, opcode in bits 31..25
    localparam logic [6:0] OP_LU12I_W = 7'h0a;

    // 2RI16 branches, opcode in bits 31..26
    localparam logic [5:0] OP_BEQ = 6'h16;
    localparam logic [5:0] OP_BNE = 6'h17;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_t;

    // one instruction word, register view or immediate view
    typedef union packed {
        struct packed {
            logic [16:0]       opcode;
            logic [REG_AW-1:0] rk;
            logic [REG_AW-1:0] rj;
            logic [REG_AW-1:0] rd;
        } r;
        struct packed {
            logic [5:0]        op6;
            // low 12 bits are si12, all 16 are offs16
            logic [15:0]       imm16;
            logic [REG_AW-1:0] rj;
            logic [REG_AW-1:0] rd;
        } i;
    } inst_t;

endpackage

/* logic/reg_file.sv */
module reg_file import core_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  logic              r1_en,
    input  logic [REG_AW-1:0] r1_addr,
    output logic [DATA_W-1:0] r1_data,
    input  logic              r2_en,
    input  logic [REG_AW-1:0] r2_addr,
    output logic [DATA_W-1:0] r2_data,
    input  logic              rw_en,
    input  logic [REG_AW-1:0] rw_addr,
    input  logic [DATA_W-1:0] rw_data
);
    logic [DATA_W-1:0] regs [REG_NUM];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (rw_en && rw_addr != '0) begin
            regs[rw_addr] <= rw_data;
        end
    end

    assign r1_data = (r1_en && r1_addr != '0) ? regs[r1_addr] : '0;
    assign r2_data = (r2_en && r2_addr != '0) ? regs[r2_addr] : '0;

endmodule

/* logic/reg_bypass.sv */
module reg_bypass import core_pkg::*; (
    input  logic              req_en,
    input  logic [REG_AW-1:0] req_addr,
    input  logic              ex_valid,
    input  logic              ex_rw_en,
    input  logic [REG_AW-1:0] ex_rw_addr,
    input  logic [DATA_W-1:0] ex_result,
    input  logic              ex_is_load,
    input  logic              mem_valid,
    input  logic              mem_rw_en,
    input  logic [REG_AW-1:0] mem_rw_addr,
    input  logic [DATA_W-1:0] mem_result,
    input  logic              mem_is_load,
    input  logic              wb_rw_en,
    input  logic [REG_AW-1:0] wb_rw_addr,
    input  logic [DATA_W-1:0] wb_rw_data,
    input  logic [DATA_W-1:0] rf_data,
    output logic              rf_en,
    output logic [REG_AW-1:0] rf_addr,
    output logic [DATA_W-1:0] req_data,
    output logic              hazard
);
    logic live, ex_hit, mem_hit, wb_hit;

    // r0 is never forwarded
    assign live    = req_en && (req_addr != '0);
    assign ex_hit  = live && ex_valid && ex_rw_en && (ex_rw_addr == req_addr);
    assign mem_hit = live && mem_valid && mem_rw_en && (mem_rw_addr == req_addr);
    assign wb_hit  = live && wb_rw_en && (wb_rw_addr == req_addr);

    assign rf_en   = req_en;
    assign rf_addr = req_addr;

    // youngest producer wins
    assign req_data = ex_hit  ? ex_result  :
                      mem_hit ? mem_result :
                      wb_hit  ? wb_rw_data : rf_data;

    // load data only exists in writeback, so hold while a load is in EX or MEM
    assign hazard = ex_hit ? ex_is_load : (mem_hit && mem_is_load);

endmodule

/* logic/inst_fetch.sv */
module inst_fetch import core_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  logic              id_stall,
    input  logic              ex_flush,
    input  logic [DATA_W-1:0] branch_target,
    input  logic [DATA_W-1:0] imem_rdata,
    output logic              imem_en,
    output logic [DATA_W-1:0] imem_addr,
    output logic              if_valid,
    output logic [DATA_W-1:0] if_pc,
    output inst_t             if_inst
);
    logic [DATA_W-1:0] pc;
    logic              held;
    inst_t             inst_hold;

    // pc is the address requested this cycle
    assign imem_en   = !id_stall;
    assign imem_addr = pc;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (ex_flush) begin
            pc <= branch_target;
        end else if (!id_stall) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clock) begin
        if (rst || ex_flush) begin
            if_valid <= 1'b0;
        end else if (!id_stall) begin
            if_valid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!id_stall) begin
            if_pc <= pc;
        end
    end

    // memory output is not requested during a stall, keep a copy
    always_ff @(posedge clock) begin
        if (rst) begin
            held <= 1'b0;
        end else begin
            held <= id_stall && !ex_flush;
        end
        inst_hold <= if_inst;
    end

    assign if_inst = held ? inst_hold : imem_rdata;

    // a kept slot always faces a bubble in EX and never a flush
    a_flush_not_held: assert property (@(posedge clock) disable iff (rst)
        !(ex_flush && held));

endmodule

/* logic/inst_decode.sv */
module inst_decode import core_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  logic              if_valid,
    input  logic [DATA_W-1:0] if_pc,
    input  inst_t             if_inst,
    input  logic              id_stall,
    input  logic              ex_flush,
    input  logic [DATA_W-1:0] r1_data,
    input  logic [DATA_W-1:0] r2_data,
    output logic              r1_en,
    output logic [REG_AW-1:0] r1_addr,
    output logic              r2_en,
    output logic [REG_AW-1:0] r2_addr,
    output logic              ex_valid,
    output logic [DATA_W-1:0] ex_pc,
    output alu_op_t           ex_alu_op,
    output logic [DATA_W-1:0] ex_a,
    output logic [DATA_W-1:0] ex_b,
    output logic [DATA_W-1:0] ex_store_data,
    output logic              ex_is_load,
    output logic              ex_is_store,
    output logic              ex_is_beq,
    output logic              ex_is_bne,
    output logic [DATA_W-1:0] ex_branch_target,
    output logic              ex_rw_en,
    output logic [REG_AW-1:0] ex_rw_addr
);
    logic              is_rr, is_addi, is_lu12i, is_ld, is_st, is_beq, is_bne, is_br;
    alu_op_t           rr_op, alu_op;
    logic [DATA_W-1:0] si12_ext, si20_up, offs_ext, op_b;

    always_comb begin
        is_rr = 1'b1;
        rr_op = ALU_ADD;
        case (if_inst.r.opcode)
            OP_ADD_W: rr_op = ALU_ADD;
            OP_SUB_W: rr_op = ALU_SUB;
            OP_AND:   rr_op = ALU_AND;
            OP_OR:    rr_op = ALU_OR;
            OP_XOR:   rr_op = ALU_XOR;
            OP_SLT:   rr_op = ALU_SLT;
            OP_SLTU:  rr_op = ALU_SLTU;
            default:  is_rr = 1'b0;
        endcase
    end

    assign is_addi  = if_inst.r.opcode[16:7] == OP_ADDI_W;
    assign is_ld    = if_inst.r.opcode[16:7] == OP_LD_W;
    assign is_st    = if_inst.r.opcode[16:7] == OP_ST_W;
    assign is_lu12i = if_inst.r.opcode[16:10] == OP_LU12I_W;
    assign is_beq   = if_inst.i.op6 == OP_BEQ;
    assign is_bne   = if_inst.i.op6 == OP_BNE;
    assign is_br    = is_beq || is_bne;

    // immediates, si20 straddles imm16 and the rj field
    assign si12_ext = {{20{if_inst.i.imm16[11]}}, if_inst.i.imm16[11:0]};
    assign si20_up  = {if_inst.i.imm16[14:0], if_inst.i.rj, 12'b0};
    assign offs_ext = {{14{if_inst.i.imm16[15]}}, if_inst.i.imm16, 2'b00};

    // r2 is rk for 3R forms, rd for stores and branch compares
    assign r1_en   = if_valid && (is_rr || is_addi || is_ld || is_st || is_br);
    assign r1_addr = if_inst.i.rj;
    assign r2_en   = if_valid && (is_rr || is_st || is_br);
    assign r2_addr = is_rr ? if_inst.r.rk : if_inst.i.rd;

    assign alu_op = is_lu12i ? ALU_PASS_B : (is_rr ? rr_op : ALU_ADD);
    assign op_b   = (is_rr || is_br) ? r2_data : (is_lu12i ? si20_up : si12_ext);

    // bubble on stall or flush
    always_ff @(posedge clock) begin
        if (rst || id_stall || ex_flush) begin
            ex_valid    <= 1'b0;
            ex_is_load  <= 1'b0;
            ex_is_store <= 1'b0;
            ex_is_beq   <= 1'b0;
            ex_is_bne   <= 1'b0;
            ex_rw_en    <= 1'b0;
        end else begin
            ex_valid    <= if_valid;
            ex_is_load  <= if_valid && is_ld;
            ex_is_store <= if_valid && is_st;
            ex_is_beq   <= if_valid && is_beq;
            ex_is_bne   <= if_valid && is_bne;
            ex_rw_en    <= if_valid && (is_rr || is_addi || is_lu12i || is_ld);
        end
    end

    always_ff @(posedge clock) begin
        ex_pc            <= if_pc;
        ex_alu_op        <= alu_op;
        ex_a             <= r1_data;
        ex_b             <= op_b;
        ex_store_data    <= r2_data;
        ex_branch_target <= if_pc + offs_ext;
        ex_rw_addr       <= if_inst.i.rd;
    end

endmodule

/* logic/execute.sv */
module execute import core_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  logic              ex_valid,
    input  logic [DATA_W-1:0] ex_pc,
    input  alu_op_t           ex_alu_op,
    input  logic [DATA_W-1:0] ex_a,
    input  logic [DATA_W-1:0] ex_b,
    input  logic [DATA_W-1:0] ex_store_data,
    input  logic              ex_is_load,
    input  logic              ex_is_store,
    input  logic              ex_is_beq,
    input  logic              ex_is_bne,
    input  logic [DATA_W-1:0] ex_branch_target,
    input  logic              ex_rw_en,
    input  logic [REG_AW-1:0] ex_rw_addr,
    output logic [DATA_W-1:0] ex_result,
    output logic              ex_flush,
    output logic [DATA_W-1:0] branch_target,
    output logic              mem_valid,
    output logic [DATA_W-1:0] mem_pc,
    output logic [DATA_W-1:0] mem_result,
    output logic [DATA_W-1:0] mem_store_data,
    output logic              mem_is_load,
    output logic              mem_is_store,
    output logic              mem_rw_en,
    output logic [REG_AW-1:0] mem_rw_addr
);
    logic equal;

    // also the address for loads and stores
    always_comb begin
        case (ex_alu_op)
            ALU_ADD:  ex_result = ex_a + ex_b;
            ALU_SUB:  ex_result = ex_a - ex_b;
            ALU_AND:  ex_result = ex_a & ex_b;
            ALU_OR:   ex_result = ex_a | ex_b;
            ALU_XOR:  ex_result = ex_a ^ ex_b;
            ALU_SLT:  ex_result = {31'b0, $signed(ex_a) < $signed(ex_b)};
            ALU_SLTU: ex_result = {31'b0, ex_a < ex_b};
            default:  ex_result = ex_b;
        endcase
    end

    // not-taken is the only prediction, a taken branch redirects
    assign equal         = ex_a == ex_b;
    assign ex_flush      = ex_valid && ((ex_is_beq && equal) || (ex_is_bne && !equal));
    assign branch_target = ex_branch_target;

    always_ff @(posedge clock) begin
        if (rst) begin
            mem_valid    <= 1'b0;
            mem_is_load  <= 1'b0;
            mem_is_store <= 1'b0;
            mem_rw_en    <= 1'b0;
        end else begin
            mem_valid    <= ex_valid;
            mem_is_load  <= ex_valid && ex_is_load;
            mem_is_store <= ex_valid && ex_is_store;
            mem_rw_en    <= ex_valid && ex_rw_en;
        end
    end

    always_ff @(posedge clock) begin
        mem_pc         <= ex_pc;
        mem_result     <= ex_result;
        mem_store_data <= ex_store_data;
        mem_rw_addr    <= ex_rw_addr;
    end

endmodule

/* logic/mem_access.sv */
module mem_access import core_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  logic              mem_valid,
    input  logic [DATA_W-1:0] mem_pc,
    input  logic [DATA_W-1:0] mem_result,
    input  logic [DATA_W-1:0] mem_store_data,
    input  logic              mem_is_load,
    input  logic              mem_is_store,
    input  logic              mem_rw_en,
    input  logic [REG_AW-1:0] mem_rw_addr,
    input  logic [DATA_W-1:0] dmem_rd_data,
    output logic              dmem_rd_en,
    output logic              dmem_wr_en,
    output logic [DATA_W-1:0] dmem_addr,
    output logic [3:0]        dmem_wr_mask,
    output logic [DATA_W-1:0] dmem_wr_data,
    output logic              wb_rw_en,
    output logic [REG_AW-1:0] wb_rw_addr,
    output logic [DATA_W-1:0] wb_rw_data,
    output logic [DATA_W-1:0] debug_wb_pc,
    output logic [3:0]        debug_wb_rf_wen,
    output logic [REG_AW-1:0] debug_wb_rf_wnum,
    output logic [DATA_W-1:0] debug_wb_rf_wdata
);
    logic              wb_valid, wb_is_load, wb_writes;
    logic [DATA_W-1:0] wb_pc, wb_result;

    // word accesses only
    assign dmem_rd_en   = mem_valid && mem_is_load;
    assign dmem_wr_en   = mem_valid && mem_is_store;
    assign dmem_addr    = {mem_result[DATA_W-1:2], 2'b00};
    assign dmem_wr_mask = 4'b1111;
    assign dmem_wr_data = mem_store_data;

    always_ff @(posedge clock) begin
        if (rst) begin
            wb_valid   <= 1'b0;
            wb_is_load <= 1'b0;
            wb_writes  <= 1'b0;
        end else begin
            wb_valid   <= mem_valid;
            wb_is_load <= mem_valid && mem_is_load;
            wb_writes  <= mem_valid && mem_rw_en;
        end
    end

    always_ff @(posedge clock) begin
        wb_pc      <= mem_pc;
        wb_result  <= mem_result;
        wb_rw_addr <= mem_rw_addr;
    end

    // read data arrives this cycle
    assign wb_rw_data = wb_is_load ? dmem_rd_data : wb_result;
    assign wb_rw_en   = wb_valid && wb_writes && (wb_rw_addr != '0);

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {4{wb_rw_en}};
    assign debug_wb_rf_wnum  = wb_rw_addr;
    assign debug_wb_rf_wdata = wb_rw_data;

    a_one_strobe: assert property (@(posedge clock) disable iff (rst)
        !(dmem_rd_en && dmem_wr_en));

endmodule

/* logic/core_top.sv */
module core_top import core_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    output logic              imem_en,
    output logic [DATA_W-1:0] imem_addr,
    input  logic [DATA_W-1:0] imem_rdata,
    output logic              dmem_rd_en,
    output logic              dmem_wr_en,
    output logic [DATA_W-1:0] dmem_addr,
    output logic [3:0]        dmem_wr_mask,
    output logic [DATA_W-1:0] dmem_wr_data,
    input  logic [DATA_W-1:0] dmem_rd_data,
    output logic [DATA_W-1:0] debug_wb_pc,
    output logic [3:0]        debug_wb_rf_wen,
    output logic [REG_AW-1:0] debug_wb_rf_wnum,
    output logic [DATA_W-1:0] debug_wb_rf_wdata
);
    logic              id_stall, ex_flush, hazard1, hazard2;
    logic [DATA_W-1:0] branch_target;
    logic              if_valid;
    logic [DATA_W-1:0] if_pc;
    inst_t             if_inst;

    logic              r1_en, r2_en, rf1_en, rf2_en;
    logic [REG_AW-1:0] r1_addr, r2_addr, rf1_addr, rf2_addr;
    logic [DATA_W-1:0] r1_data, r2_data, rf1_data, rf2_data;

    logic              ex_valid, ex_is_load, ex_is_store, ex_is_beq, ex_is_bne, ex_rw_en;
    logic [DATA_W-1:0] ex_pc, ex_a, ex_b, ex_store_data, ex_branch_target, ex_result;
    logic [REG_AW-1:0] ex_rw_addr;
    alu_op_t           ex_alu_op;

    logic              mem_valid, mem_is_load, mem_is_store, mem_rw_en;
    logic [DATA_W-1:0] mem_pc, mem_result, mem_store_data;
    logic [REG_AW-1:0] mem_rw_addr;

    logic              rw_en;
    logic [REG_AW-1:0] rw_addr;
    logic [DATA_W-1:0] rw_data;

    // load-use from either operand
    assign id_stall = hazard1 | hazard2;

    inst_fetch u_fetch (
        .clock, .rst, .id_stall, .ex_flush, .branch_target, .imem_rdata,
        .imem_en, .imem_addr, .if_valid, .if_pc, .if_inst
    );

    inst_decode u_decode (
        .clock, .rst, .if_valid, .if_pc, .if_inst, .id_stall, .ex_flush,
        .r1_data, .r2_data, .r1_en, .r1_addr, .r2_en, .r2_addr,
        .ex_valid, .ex_pc, .ex_alu_op, .ex_a, .ex_b, .ex_store_data,
        .ex_is_load, .ex_is_store, .ex_is_beq, .ex_is_bne, .ex_branch_target,
        .ex_rw_en, .ex_rw_addr
    );

    reg_bypass u_bypass1 (
        .req_en(r1_en), .req_addr(r1_addr),
        .ex_valid, .ex_rw_en, .ex_rw_addr, .ex_result, .ex_is_load,
        .mem_valid, .mem_rw_en, .mem_rw_addr, .mem_result, .mem_is_load,
        .wb_rw_en(rw_en), .wb_rw_addr(rw_addr), .wb_rw_data(rw_data),
        .rf_data(rf1_data), .rf_en(rf1_en), .rf_addr(rf1_addr),
        .req_data(r1_data), .hazard(hazard1)
    );

    reg_bypass u_bypass2 (
        .req_en(r2_en), .req_addr(r2_addr),
        .ex_valid, .ex_rw_en, .ex_rw_addr, .ex_result, .ex_is_load,
        .mem_valid, .mem_rw_en, .mem_rw_addr, .mem_result, .mem_is_load,
        .wb_rw_en(rw_en), .wb_rw_addr(rw_addr), .wb_rw_data(rw_data),
        .rf_data(rf2_data), .rf_en(rf2_en), .rf_addr(rf2_addr),
        .req_data(r2_data), .hazard(hazard2)
    );

    reg_file u_regs (
        .clock, .rst,
        .r1_en(rf1_en), .r1_addr(rf1_addr), .r1_data(rf1_data),
        .r2_en(rf2_en), .r2_addr(rf2_addr), .r2_data(rf2_data),
        .rw_en, .rw_addr, .rw_data
    );

    execute u_execute (
        .clock, .rst, .ex_valid, .ex_pc, .ex_alu_op, .ex_a, .ex_b, .ex_store_data,
        .ex_is_load, .ex_is_store, .ex_is_beq, .ex_is_bne, .ex_branch_target,
        .ex_rw_en, .ex_rw_addr, .ex_result, .ex_flush, .branch_target,
        .mem_valid, .mem_pc, .mem_result, .mem_store_data, .mem_is_load,
        .mem_is_store, .mem_rw_en, .mem_rw_addr
    );

    mem_access u_mem (
        .clock, .rst, .mem_valid, .mem_pc, .mem_result, .mem_store_data,
        .mem_is_load, .mem_is_store, .mem_rw_en, .mem_rw_addr, .dmem_rd_data,
        .dmem_rd_en, .dmem_wr_en, .dmem_addr, .dmem_wr_mask, .dmem_wr_data,
        .wb_rw_en(rw_en), .wb_rw_addr(rw_addr), .wb_rw_data(rw_data),
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

endmodule

/* sim/core_tb.sv */
module core_tb import core_pkg::*; ();

    localparam int PROG_LEN       = 400;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 4 + 200;
    localparam int TIMEOUT_TIME   = (TIMEOUT_CYCLES + 10) * 10;

    // instruction kinds, the first seven are the 3R forms
    localparam int K_ADD   = 0;
    localparam int K_SUB   = 1;
    localparam int K_AND   = 2;
    localparam int K_OR    = 3;
    localparam int K_XOR   = 4;
    localparam int K_SLT   = 5;
    localparam int K_SLTU  = 6;
    localparam int K_ADDI  = 7;
    localparam int K_LU12I = 8;
    localparam int K_LD    = 9;
    localparam int K_ST    = 10;
    localparam int K_BEQ   = 11;
    localparam int K_BNE   = 12;

    logic              clock, rst;
    logic              imem_en, dmem_rd_en, dmem_wr_en;
    logic [DATA_W-1:0] imem_addr, imem_rdata, dmem_addr, dmem_wr_data, dmem_rd_data;
    logic [DATA_W-1:0] debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0]        dmem_wr_mask, debug_wb_rf_wen;
    logic [REG_AW-1:0] debug_wb_rf_wnum;

    logic [DATA_W-1:0] imem [2**IMEM_AW];
    logic [DATA_W-1:0] dmem [2**DMEM_AW];

    // program fields as generated
    int                kind  [2**IMEM_AW];
    logic [REG_AW-1:0] f_rd  [2**IMEM_AW];
    logic [REG_AW-1:0] f_rj  [2**IMEM_AW];
    logic [REG_AW-1:0] f_rk  [2**IMEM_AW];
    logic [19:0]       f_imm [2**IMEM_AW];

    // expected register writes and stores, in program order
    logic [DATA_W-1:0] exp_pc[$], exp_val[$], st_addr[$], st_data[$];
    logic [REG_AW-1:0] exp_rd[$];

    logic               ireq, dreq;
    logic [IMEM_AW-1:0] iidx;
    logic [DMEM_AW-1:0] didx;
    int                 mismatches, failures, cycles_out;

    core_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [DATA_W-1:0] fill_word(int i);
        return {~i[15:0], i[15:0]} ^ 32'h3c5a_0f96;
    endfunction

    function automatic logic [16:0] rr_opcode(int k);
        case (k)
            K_SUB:   return OP_SUB_W;
            K_AND:   return OP_AND;
            K_OR:    return OP_OR;
            K_XOR:   return OP_XOR;
            K_SLT:   return OP_SLT;
            K_SLTU:  return OP_SLTU;
            default: return OP_ADD_W;
        endcase
    endfunction

    task automatic report_mismatch(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
        mismatches++;
        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
    endtask

    task automatic gen_program();
        inst_t              w;
        int                 k;
        int                 lim;
        logic [IMEM_AW-1:0] p;
        imem = '{default: '0};
        for (int i = 0; i <= PROG_LEN; i++) begin
            p        = IMEM_AW'(i);
            k        = (i == PROG_LEN) ? K_BEQ : int'($urandom % 13);
            kind[p]  = k;
            f_rd[p]  = REG_AW'($urandom % 8);
            f_rj[p]  = REG_AW'($urandom % 8);
            f_rk[p]  = REG_AW'($urandom % 8);
            f_imm[p] = 20'($urandom);
            if (k == K_LD || k == K_ST) begin
                // rj = r0, word aligned, low half of data memory
                f_rj[p]  = '0;
                f_imm[p] = 20'(($urandom % 512) * 4);
            end else if (k == K_LU12I) begin
                f_rj[p] = f_imm[p][4:0];
            end else if (k >= K_BEQ) begin
                lim      = (PROG_LEN - i < 8) ? PROG_LEN - i : 8;
                f_imm[p] = 20'(1 + $urandom % lim);
            end
            // final self-loop, beq r0,r0,0
            if (i == PROG_LEN) begin
                f_rd[p]  = '0;
                f_rj[p]  = '0;
                f_imm[p] = '0;
            end
            w      = '0;
            w.i.rd = f_rd[p];
            w.i.rj = f_rj[p];
            if (k <= K_SLTU) begin
                w.r.opcode = rr_opcode(k);
                w.r.rk     = f_rk[p];
            end else if (k == K_LU12I) begin
                w.i.imm16[14:0]   = f_imm[p][19:5];
                w.r.opcode[16:10] = OP_LU12I_W;
            end else if (k >= K_BEQ) begin
                w.i.imm16 = f_imm[p][15:0];
                w.i.op6   = (k == K_BEQ) ? OP_BEQ : OP_BNE;
            end else begin
                w.i.imm16[11:0]  = f_imm[p][11:0];
                w.r.opcode[16:7] = (k == K_ADDI) ? OP_ADDI_W : (k == K_LD) ? OP_LD_W : OP_ST_W;
            end
            imem[p] = w;
        end
    endtask

    task automatic run_model();
        logic [DATA_W-1:0]  regs [REG_NUM];
        logic [DATA_W-1:0]  dm [2**DMEM_AW];
        logic [DATA_W-1:0]  a, b, val, addr;
        logic [IMEM_AW-1:0] p;
        logic               wr, taken;
        int                 idx;
        regs = '{default: '0};
        dm   = dmem;
        idx  = 0;
        while (idx != PROG_LEN) begin
            p    = IMEM_AW'(idx);
            a    = regs[f_rj[p]];
            b    = regs[f_rk[p]];
            addr = a + {{20{f_imm[p][11]}}, f_imm[p][11:0]};
            wr   = 1'b1;
            val  = '0;
            case (kind[p])
                K_ADD:   val = a + b;
                K_SUB:   val = a - b;
                K_AND:   val = a & b;
                K_OR:    val = a | b;
                K_XOR:   val = a ^ b;
                K_SLT:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_SLTU:  val = (a < b) ? 32'd1 : 32'd0;
                K_ADDI:  val = addr;
                K_LU12I: val = {f_imm[p], 12'b0};
                K_LD:    val = dm[addr[DMEM_AW+1:2]];
                K_ST: begin
                    wr = 1'b0;
                    st_addr.push_back({addr[DATA_W-1:2], 2'b00});
                    st_data.push_back(regs[f_rd[p]]);
                    dm[addr[DMEM_AW+1:2]] = regs[f_rd[p]];
                end
                default: wr = 1'b0;
            endcase
            if (wr && f_rd[p] != '0) begin
                exp_pc.push_back(RESET_PC + 32'(idx * 4));
                exp_rd.push_back(f_rd[p]);
                exp_val.push_back(val);
                regs[f_rd[p]] = val;
            end
            taken = (kind[p] == K_BEQ && regs[f_rj[p]] == regs[f_rd[p]])
                 || (kind[p] == K_BNE && regs[f_rj[p]] != regs[f_rd[p]]);
            idx = taken ? idx + int'(f_imm[p][15:0]) : idx + 1;
        end
    endtask

    task automatic report_and_finish();
        $display("closing: %0d mismatches, %0d failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    // requests are sampled mid-cycle, answers land just after the next edge
    always @(posedge clock) begin
        #1;
        if (ireq) begin
            imem_rdata = imem[iidx];
        end
        if (dreq) begin
            dmem_rd_data = dmem[didx];
        end
    end

    always @(negedge clock) begin
        logic [DATA_W-1:0] e_pc, e_val, e_addr, e_data;
        logic [REG_AW-1:0] e_rd;
        ireq = imem_en;
        iidx = imem_addr[IMEM_AW+1:2];
        dreq = dmem_rd_en;
        didx = dmem_addr[DMEM_AW+1:2];
        if (!rst) begin
            cycles_out++;
        end
        if (!rst && cycles_out == 1 && (imem_en !== 1'b1 || imem_addr !== RESET_PC)) begin
            failures++;
            $display("%0t: first fetch after reset is not a request for %h", $time, RESET_PC);
        end
        // first fetch is in memory access at cycle 4 and in writeback at cycle 5
        if ((rst || cycles_out < 5) && debug_wb_rf_wen !== 4'h0) begin
            failures++;
            $display("%0t: register write before the first instruction reached writeback",
                     $time);
        end
        if ((rst || cycles_out < 4) && dmem_wr_en !== 1'b0) begin
            failures++;
            $display("%0t: store before the first instruction reached memory access", $time);
        end
        if (!rst && debug_wb_rf_wen != 4'h0) begin
            if (exp_pc.size() == 0) begin
                failures++;
                $display("%0t: register write to r%0d beyond the model's writes", $time,
                         debug_wb_rf_wnum);
            end else begin
                e_pc  = exp_pc.pop_front();
                e_rd  = exp_rd.pop_front();
                e_val = exp_val.pop_front();
                if (debug_wb_rf_wen !== 4'hf) report_mismatch("debug_wb_rf_wen", 32'hf,
                                                             32'(debug_wb_rf_wen));
                if (debug_wb_pc !== e_pc) report_mismatch("debug_wb_pc", e_pc, debug_wb_pc);
                if (debug_wb_rf_wnum !== e_rd) report_mismatch("debug_wb_rf_wnum", 32'(e_rd),
                                                              32'(debug_wb_rf_wnum));
                if (debug_wb_rf_wdata !== e_val) report_mismatch("debug_wb_rf_wdata", e_val,
                                                                debug_wb_rf_wdata);
            end
        end
        if (!rst && dmem_wr_en) begin
            if (st_addr.size() == 0) begin
                failures++;
                $display("%0t: store to %h beyond the model's stores", $time, dmem_addr);
            end else begin
                e_addr = st_addr.pop_front();
                e_data = st_data.pop_front();
                if (dmem_addr !== e_addr) report_mismatch("dmem_addr", e_addr, dmem_addr);
                if (dmem_wr_data !== e_data) report_mismatch("dmem_wr_data", e_data, dmem_wr_data);
                if (dmem_wr_mask !== 4'hf) report_mismatch("dmem_wr_mask", 32'hf,
                                                          32'(dmem_wr_mask));
            end
            dmem[dmem_addr[DMEM_AW+1:2]] = dmem_wr_data;
        end
    end

    initial begin
        rst          = 1'b1;
        imem_rdata   = '0;
        dmem_rd_data = '0;
        ireq         = 1'b0;
        dreq         = 1'b0;
        mismatches   = 0;
        failures     = 0;
        cycles_out   = 0;
        void'($urandom(32'hd11c));
        gen_program();
        for (int i = 0; i < 2**DMEM_AW; i++) begin
            dmem[DMEM_AW'(i)] = fill_word(i);
        end
        run_model();
        repeat (10) @(posedge clock);
        #1 rst = 1'b0;
        while (exp_pc.size() != 0 || st_addr.size() != 0) begin
            @(posedge clock);
        end
        // self-loop spins, nothing more may retire
        repeat (20) @(posedge clock);
        report_and_finish();
    end

    initial begin
        #(TIMEOUT_TIME);
        $display("timeout after %0d cycles", TIMEOUT_CYCLES);
        if (exp_pc.size() != 0) begin
            $display("%0d expected register writes never retired", exp_pc.size());
        end
        if (st_addr.size() != 0) begin
            $display("%0d expected stores never issued", st_addr.size());
        end
        failures++;
        report_and_finish();
    end

endmodule

/* sim.f */
logic/core_pkg.sv
logic/reg_file.sv
logic/reg_bypass.sv
logic/inst_fetch.sv
logic/inst_decode.sv
logic/execute.sv
logic/mem_access.sv
logic/core_top.sv
sim/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Something failed

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
